/* logic/mem_stage_pkg.sv */
package mem_stage_pkg;

    localparam int XLEN       = 32;
    localparam int DWORD_BITS = 64;
    localparam int BYTE_LANES = DWORD_BITS / 8;
    localparam int REG_BITS   = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [DWORD_BITS-1:0] dword_t;
    typedef logic [BYTE_LANES-1:0] byte_en_t;
    typedef logic [REG_BITS-1:0]   reg_idx_t;

    // bit 2 marks unsigned, bits 1:0 give the width
    typedef logic [2:0] mem_size_t;

    localparam logic [1:0] SIZE_BYTE   = 2'b00;
    localparam logic [1:0] SIZE_HALF   = 2'b01;
    localparam logic [1:0] SIZE_WORD   = 2'b10;
    localparam logic [1:0] SIZE_DOUBLE = 2'b11;

    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command_e;

    typedef struct packed {
        xlen_t     pc;
        xlen_t     rs2_value;    // store data
        reg_idx_t  dest_reg_idx;
        mem_size_t mem_size;
        logic      wr_mem;
        logic      valid;
    } is_packet_t;

    localparam is_packet_t NOP_PACKET = '{
        pc:           '0,
        rs2_value:    '0,
        dest_reg_idx: '0,
        mem_size:     {1'b0, SIZE_DOUBLE},
        wr_mem:       1'b0,
        valid:        1'b0
    };

endpackage

/* logic/dcache_if.sv */
`timescale 1ns/10ps

interface dcache_if;
    import mem_stage_pkg::*;

    bus_command_e command;  // BUS_STORE while a store is offered
    xlen_t        addr;     // byte address, not yet aligned
    dword_t       data;     // zero-extended store value
    mem_size_t    size;
    logic         finish;   // one cycle per accepted store

    modport store (
        output command,
        output addr,
        output data,
        output size,
        input  finish
    );

    modport port (
        input  command,
        input  addr,
        input  data,
        input  size,
        output finish
    );

endinterface

/* logic/store_unit.sv */
`timescale 1ns/10ps

module store_unit (
    input  logic                      clock,
    input  logic                      reset,
    input  mem_stage_pkg::xlen_t      opa,
    input  mem_stage_pkg::xlen_t      opb,
    input  mem_stage_pkg::is_packet_t is_packet_in,
    input  logic                      start,
    input  logic                      rob_start,
    dcache_if.store                   dc,
    output mem_stage_pkg::is_packet_t is_packet_out,
    output logic                      busy,
    output logic                      done
);
    import mem_stage_pkg::*;

    is_packet_t packet_q;
    is_packet_t next_packet;
    is_packet_t cur_packet;
    xlen_t      addr_q;
    xlen_t      eff_addr;
    xlen_t      cur_addr;
    logic       next_busy;

    assign eff_addr = opa + opb;  // effective address

    // in the start cycle the live inputs are used, so a store that is
    // already at the head of the ROB goes out without a wait cycle
    assign cur_packet = start ? is_packet_in : packet_q;
    assign cur_addr   = start ? eff_addr : addr_q;

    always_comb begin
        if (rob_start && (start || busy) && cur_packet.wr_mem) begin
            dc.command = BUS_STORE;
        end else begin
            dc.command = BUS_NONE;  // not committed yet
        end
    end

    assign dc.addr = cur_addr;
    assign dc.data = dword_t'(cur_packet.rs2_value);  // zero-extend
    assign dc.size = cur_packet.mem_size;

    assign done          = dc.finish && (start || busy);
    assign is_packet_out = cur_packet;

    always_comb begin
        if (start) begin
            next_packet = is_packet_in;
        end else if (busy) begin
            next_packet = packet_q;  // hold until done
        end else begin
            next_packet = NOP_PACKET;
        end
    end

    always_comb begin
        if (start) begin
            next_busy = 1'b1;
        end else if (done) begin
            next_busy = 1'b0;
        end else begin
            next_busy = busy;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy     <= 1'b0;
            packet_q <= NOP_PACKET;
        end else begin
            busy     <= next_busy;
            packet_q <= next_packet;
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            addr_q <= eff_addr;  // held while waiting for commit
        end
    end

    // issue logic must wait for busy to drop
    start_while_idle: assert property (
        @(posedge clock) disable iff (reset)
        start |-> !busy
    ) else $error("store_unit: start while busy");

    // only stores are routed to this unit by issue
    started_is_store: assert property (
        @(posedge clock) disable iff (reset)
        start |-> is_packet_in.wr_mem
    ) else $error("store_unit: started packet without wr_mem");

endmodule

/* logic/store_mem_port.sv */
`timescale 1ns/10ps

module store_mem_port (
    input  logic                    clock,
    input  logic                    reset,
    dcache_if.port                  dc,
    output logic                    mem_req,
    output mem_stage_pkg::xlen_t    mem_addr,
    output mem_stage_pkg::dword_t   mem_wdata,
    output mem_stage_pkg::byte_en_t mem_byte_en,
    input  logic                    mem_ack
);
    import mem_stage_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_DROP,
        FINISH
    } state_e;

    state_e   state;
    state_e   next_state;
    logic     accept;
    logic     addr_aligned;
    logic [2:0] lane;
    byte_en_t lane_mask;
    xlen_t    addr_q;
    dword_t   wdata_q;
    byte_en_t byte_en_q;

    assign accept = (state == IDLE) && (dc.command == BUS_STORE);
    assign lane   = dc.addr[2:0];  // first byte lane of the access

    // lane count and natural alignment from the size code
    always_comb begin
        case (dc.size[1:0])
            SIZE_BYTE: begin
                lane_mask    = 8'h01;
                addr_aligned = 1'b1;
            end
            SIZE_HALF: begin
                lane_mask    = 8'h03;
                addr_aligned = (lane[0] == 1'b0);
            end
            SIZE_WORD: begin
                lane_mask    = 8'h0f;
                addr_aligned = (lane[1:0] == 2'b00);
            end
            default: begin
                lane_mask    = 8'hff;
                addr_aligned = (lane == 3'b000);
            end
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    next_state = REQ;
                end
            end
            REQ: begin
                if (mem_ack) begin
                    next_state = WAIT_DROP;  // req drops here
                end
            end
            WAIT_DROP: begin
                if (!mem_ack) begin
                    next_state = FINISH;
                end
            end
            default: begin
                next_state = IDLE;  // finish lasts one cycle
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // payload is captured once and stays stable through the handshake
    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q    <= {dc.addr[XLEN-1:3], 3'b000};
            wdata_q   <= dc.data << {lane, 3'b000};
            byte_en_q <= lane_mask << lane;
        end
    end

    assign mem_req     = (state == REQ);
    assign mem_addr    = addr_q;
    assign mem_wdata   = wdata_q;
    assign mem_byte_en = byte_en_q;
    assign dc.finish   = (state == FINISH);

    // req falls only after ack was seen, while the memory still holds ack
    req_held_until_ack: assert property (
        @(posedge clock) disable iff (reset)
        $fell(mem_req) |-> $past(mem_ack) && mem_ack
    ) else $error("store_mem_port: mem_req dropped before mem_ack");

    store_addr_aligned: assert property (
        @(posedge clock) disable iff (reset)
        accept |-> addr_aligned
    ) else $error("store_mem_port: misaligned store address");

endmodule

/* logic/store_path_top.sv */
`timescale 1ns/10ps

module store_path_top (
    input  logic                     clock,
    input  logic                     reset,
    input  mem_stage_pkg::xlen_t     opa,
    input  mem_stage_pkg::xlen_t     opb,
    input  mem_stage_pkg::xlen_t     issue_pc,
    input  mem_stage_pkg::xlen_t     issue_rs2_value,
    input  mem_stage_pkg::reg_idx_t  issue_dest_reg_idx,
    input  mem_stage_pkg::mem_size_t issue_mem_size,
    input  logic                     issue_valid,
    input  logic                     start,
    input  logic                     rob_start,
    output logic                     mem_req,
    output mem_stage_pkg::xlen_t     mem_addr,
    output mem_stage_pkg::dword_t    mem_wdata,
    output mem_stage_pkg::byte_en_t  mem_byte_en,
    input  logic                     mem_ack,
    output mem_stage_pkg::xlen_t     done_pc,
    output mem_stage_pkg::reg_idx_t  done_dest_reg_idx,
    output logic                     done_valid,
    output logic                     busy,
    output logic                     done
);
    import mem_stage_pkg::*;

    is_packet_t issue_packet;
    is_packet_t done_packet;

    dcache_if dc_bus ();

    // everything issued on this path is a store
    assign issue_packet = '{
        pc:           issue_pc,
        rs2_value:    issue_rs2_value,
        dest_reg_idx: issue_dest_reg_idx,
        mem_size:     issue_mem_size,
        wr_mem:       1'b1,
        valid:        issue_valid
    };

    store_unit u_store_unit (
        .clock         (clock),
        .reset         (reset),
        .opa           (opa),
        .opb           (opb),
        .is_packet_in  (issue_packet),
        .start         (start),
        .rob_start     (rob_start),
        .dc            (dc_bus.store),
        .is_packet_out (done_packet),
        .busy          (busy),
        .done          (done)
    );

    store_mem_port u_store_mem_port (
        .clock       (clock),
        .reset       (reset),
        .dc          (dc_bus.port),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_byte_en (mem_byte_en),
        .mem_ack     (mem_ack)
    );

    assign done_pc           = done_packet.pc;
    assign done_dest_reg_idx = done_packet.dest_reg_idx;
    assign done_valid        = done_packet.valid;

endmodule

/* tb/store_path_tb.sv */
`timescale 1ns/10ps

module store_path_tb;
    import mem_stage_pkg::*;

    localparam int NUM_STORES  = 200;
    localparam int CYCLE_LIMIT = NUM_STORES * 20 + 20;  // 20 cycles per store plus reset

    typedef struct packed {
        xlen_t    addr;
        byte_en_t byte_en;
        dword_t   data;
        xlen_t    pc;
        reg_idx_t dest;
        logic     valid;
    } expect_t;

    logic      clock;
    logic      reset;
    xlen_t     opa;
    xlen_t     opb;
    xlen_t     issue_pc;
    xlen_t     issue_rs2_value;
    reg_idx_t  issue_dest_reg_idx;
    mem_size_t issue_mem_size;
    logic      issue_valid;
    logic      start;
    logic      rob_start;
    logic      mem_req;
    xlen_t     mem_addr;
    dword_t    mem_wdata;
    byte_en_t  mem_byte_en;
    logic      mem_ack;
    xlen_t     done_pc;
    reg_idx_t  done_dest_reg_idx;
    logic      done_valid;
    logic      busy;
    logic      done;

    integer    seed = 32'h58c7379c;
    int        cycles = 0;
    int        start_count = 0;
    int        done_count = 0;
    int        writes;         // mem_req rises for the store in flight
    int        handshakes;     // ack falls for the store in flight
    int        ack_delay;
    int        gap;
    logic      prev_req;
    logic      prev_ack;
    logic      exp_busy;
    logic      rob_seen;
    mem_size_t size;
    xlen_t     eff;
    xlen_t     op_a;
    xlen_t     rs2;
    expect_t   entry;
    expect_t   expect_q[$];

    store_path_top uut (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h",
                                name, actual, expected));
        end
    endtask

    // lanes lo .. lo + 2**size - 1 are written
    function automatic byte_en_t build_byte_en(input mem_size_t sz, input logic [2:0] lo);
        byte_en_t en;
        int       n;
        n = 1 << sz[1:0];
        for (int i = 0; i < 8; i++) begin
            en[i] = (i >= lo) && (i < lo + n);
        end
        return en;
    endfunction

    function automatic dword_t build_store_data(input xlen_t value, input byte_en_t en,
                                                input logic [2:0] lo);
        dword_t d;
        d = '0;
        for (int i = 0; i < 8; i++) begin
            if (en[i] && (i - lo) < 4) begin
                d[8*i +: 8] = value[8*(i - lo) +: 8];  // upper lanes of a double stay zero
            end
        end
        return d;
    endfunction

    function automatic dword_t lane_bits(input byte_en_t en);
        dword_t m;
        for (int i = 0; i < 8; i++) begin
            m[8*i +: 8] = {8{en[i]}};
        end
        return m;
    endfunction

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            abort_run("timeout: the stores did not complete within the cycle limit");
        end
    end

    // memory responder decides at negedge and drives at posedge
    initial begin
        forever begin
            @(negedge clock);
            if (mem_req && !mem_ack) begin
                ack_delay = {$random(seed)} % 5;
                repeat (ack_delay) @(negedge clock);
                @(posedge clock);
                mem_ack <= 1'b1;
                do @(negedge clock); while (mem_req);
                ack_delay = {$random(seed)} % 5;
                repeat (ack_delay) @(negedge clock);
                @(posedge clock);
                mem_ack <= 1'b0;
            end
        end
    end

    // monitor and reference model
    always @(negedge clock) begin
        if (reset) begin
            prev_req   = 1'b0;
            prev_ack   = 1'b0;
            exp_busy   = 1'b0;
            rob_seen   = 1'b0;
            writes     = 0;
            handshakes = 0;
        end else begin
            check_value("busy", busy, exp_busy);
            if (!start && !busy) begin
                check_value("done", done, 1'b0);
            end
            if (rob_start && (start || busy)) begin
                rob_seen = 1'b1;
            end
            if (mem_req && !prev_req) begin
                if (prev_ack || mem_ack) begin
                    abort_run("mem_req rose again before mem_ack had fallen");
                end
                if (!rob_seen) begin
                    abort_run("mem_req rose before rob_start permitted the store");
                end
                if (expect_q.size() == 0) begin
                    abort_run("memory write seen with no store pending");
                end
                check_value("write count", writes, 0);
                check_value("mem_addr", mem_addr, expect_q[0].addr);
                check_value("mem_byte_en", mem_byte_en, expect_q[0].byte_en);
                check_value("mem_wdata", mem_wdata & lane_bits(mem_byte_en),
                            expect_q[0].data);
                writes++;
            end
            if (prev_req && !mem_req && !prev_ack) begin
                abort_run("mem_req fell before mem_ack was raised");
            end
            if (prev_ack && !mem_ack) begin
                handshakes++;  // step 4 done
            end
            if (done) begin
                if (expect_q.size() == 0) begin
                    abort_run("done pulsed with no store pending");
                end
                check_value("writes before done", writes, 1);
                check_value("handshakes before done", handshakes, 1);
                check_value("done_pc", done_pc, expect_q[0].pc);
                check_value("done_dest_reg_idx", done_dest_reg_idx, expect_q[0].dest);
                check_value("done_valid", done_valid, expect_q[0].valid);
                void'(expect_q.pop_front());
                done_count++;
                writes     = 0;
                handshakes = 0;
                rob_seen   = 1'b0;
            end
            if (start) begin
                exp_busy = 1'b1;
            end else if (done) begin
                exp_busy = 1'b0;
            end
            prev_req = mem_req;
            prev_ack = mem_ack;
        end
    end

    initial begin
        reset              = 1'b1;
        start              = 1'b0;
        rob_start          = 1'b0;
        opa                = '0;
        opb                = '0;
        issue_pc           = '0;
        issue_rs2_value    = '0;
        issue_dest_reg_idx = '0;
        issue_mem_size     = '0;
        issue_valid        = 1'b0;
        mem_ack            = 1'b0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        repeat (5) begin  // idle after reset
            @(negedge clock);
            check_value("busy", busy, 1'b0);
            check_value("done", done, 1'b0);
            check_value("mem_req", mem_req, 1'b0);
        end
        for (int n = 0; n < NUM_STORES; n++) begin
            size          = $random(seed);
            eff           = $random(seed);
            eff           = eff & ~((32'd1 << size[1:0]) - 32'd1);  // natural alignment
            op_a          = $random(seed);
            rs2           = $random(seed);
            gap           = {$random(seed)} % 4;
            entry.addr    = {eff[31:3], 3'b000};
            entry.byte_en = build_byte_en(size, eff[2:0]);
            entry.data    = build_store_data(rs2, entry.byte_en, eff[2:0]);
            entry.pc      = $random(seed);
            entry.dest    = $random(seed);
            entry.valid   = $random(seed);
            @(posedge clock);
            start              <= 1'b1;
            opa                <= op_a;
            opb                <= eff - op_a;
            issue_pc           <= entry.pc;
            issue_rs2_value    <= rs2;
            issue_dest_reg_idx <= entry.dest;
            issue_mem_size     <= size;
            issue_valid        <= entry.valid;
            rob_start          <= (gap == 0);
            expect_q.push_back(entry);
            start_count++;
            @(posedge clock);
            start              <= 1'b0;
            opa                <= $random(seed);  // unit must use its own copy now
            opb                <= $random(seed);
            issue_pc           <= $random(seed);
            issue_rs2_value    <= $random(seed);
            issue_dest_reg_idx <= $random(seed);
            issue_mem_size     <= $random(seed);
            issue_valid        <= $random(seed);
            if (gap > 0) begin
                repeat (gap - 1) @(posedge clock);
                rob_start <= 1'b1;
            end
            do @(negedge clock); while (!done);
            @(posedge clock);
            rob_start <= 1'b0;
        end
        repeat (5) @(negedge clock);
        check_value("done count", done_count, start_count);
        check_value("pending stores", expect_q.size(), 0);
        $display(">>> PASS");
        $finish;
    end

endmodule

/* compile.f */
logic/mem_stage_pkg.sv
logic/dcache_if.sv
logic/store_unit.sv
logic/store_mem_port.sv
logic/store_path_top.sv
tb/store_path_tb.sv

/* Bender.yml */
package:
  name: store_path

sources:
  - logic/mem_stage_pkg.sv
  - logic/dcache_if.sv
  - logic/store_unit.sv
  - logic/store_mem_port.sv
  - logic/store_path_top.sv
  - target: test
    files:
      - tb/store_path_tb.sv
